// File: source/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    // major opcodes handled by this slice
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // alu group funct3
    localparam logic [2:0] f3_add  = 3'b000;   // add / sub
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;   // srl / sra
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // branch funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // one instruction word, six ways to read it
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
    } instr_u;

    typedef struct packed {
        logic [xlen-1:0] pc;
        instr_u          instr;
        logic            kill;
    } if_id_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc4;
        logic [xlen-1:0] data1;
        logic [xlen-1:0] data2;
        logic [6:0]      funct7;
        logic [2:0]      funct3;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [6:0]      opcode;
        logic [xlen-1:0] imm;
        logic            wr_reg_n;   // active low
        logic            kill;
    } id_ex_t;

    typedef struct packed {
        logic [xlen-1:0] result;
        logic [4:0]      rd;
        logic            wr_reg_n;
        logic            branch_taken;
        logic [xlen-1:0] target;
    } ex_out_t;

    typedef struct packed {
        logic            en;
        logic [4:0]      rd;
        logic [xlen-1:0] data;
    } wb_t;

endpackage

// File: source/reg_file.sv
`timescale 1ns/1ns

module reg_file
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  wb_t         wb,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [xlen-1:0] regs [1:31];   // x0 has no storage
    logic            wr_hit;

    assign wr_hit = wb.en && (wb.rd != 5'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_hit) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // write-first: a same-cycle write shows up on the read port
    always_comb begin
        if (rs1_addr == 5'd0)
            rs1_data = '0;
        else if (wr_hit && (wb.rd == rs1_addr))
            rs1_data = wb.data;
        else
            rs1_data = regs[rs1_addr];

        if (rs2_addr == 5'd0)
            rs2_data = '0;
        else if (wr_hit && (wb.rd == rs2_addr))
            rs2_data = wb.data;
        else
            rs2_data = regs[rs2_addr];
    end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder
    import rv_pkg::*;
(
    input  if_id_t      if_id,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output id_ex_t      dec
);

    instr_u          ins;
    logic [6:0]      opcode;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign ins    = if_id.instr;
    assign opcode = ins.r_fmt.opcode;

    // register addresses sit at the same bits in every format
    assign rs1_addr = ins.r_fmt.rs1;
    assign rs2_addr = ins.r_fmt.rs2;

    // immediates, all sign extended from the top instruction bit
    assign imm_i = {{20{ins.i_fmt.imm12[11]}}, ins.i_fmt.imm12};

    assign imm_s = {{20{ins.s_fmt.imm11_5[6]}},
                    ins.s_fmt.imm11_5,
                    ins.s_fmt.imm4_0};

    assign imm_b = {{19{ins.b_fmt.imm12}},
                    ins.b_fmt.imm12,
                    ins.b_fmt.imm11,
                    ins.b_fmt.imm10_5,
                    ins.b_fmt.imm4_1,
                    1'b0};

    assign imm_u = {ins.u_fmt.imm31_12, 12'b0};

    assign imm_j = {{11{ins.j_fmt.imm20}},
                    ins.j_fmt.imm20,
                    ins.j_fmt.imm19_12,
                    ins.j_fmt.imm11,
                    ins.j_fmt.imm10_1,
                    1'b0};

    always_comb begin
        dec.pc     = if_id.pc;
        dec.pc4    = if_id.pc + 32'd4;
        dec.data1  = rs1_data;
        dec.data2  = rs2_data;
        dec.funct7 = ins.r_fmt.funct7;   // imm[11:5] for op_imm, srai uses bit 5
        dec.funct3 = ins.r_fmt.funct3;
        dec.rs2    = ins.r_fmt.rs2;
        dec.rd     = ins.r_fmt.rd;
        dec.opcode = opcode;
        dec.kill   = if_id.kill;

        // immediate select by format
        case (opcode)
            op_lui,
            op_auipc:  dec.imm = imm_u;
            op_jal:    dec.imm = imm_j;
            op_jalr,
            op_imm:    dec.imm = imm_i;
            op_branch: dec.imm = imm_b;
            op_reg:    dec.imm = '0;      // no immediate
            default:   dec.imm = imm_s;   // stores and the rest
        endcase

        // only these write rd
        case (opcode)
            op_lui,
            op_auipc,
            op_jal,
            op_jalr,
            op_imm,
            op_reg:  dec.wr_reg_n = 1'b0;
            default: dec.wr_reg_n = 1'b1;
        endcase
    end

endmodule

// File: source/id_ex_regs.sv
`timescale 1ns/1ns

module id_ex_regs
    import rv_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   stall,
    input  logic   interlock,
    input  id_ex_t d,
    output id_ex_t q
);

    id_ex_t     payload;      // data side of the register
    logic [6:0] opcode_r;
    logic       wr_reg_n_r;
    logic       kill_r;
    logic       bubble;

    assign bubble = stall || interlock;

    // payload follows d every cycle, a bubble makes it don't-care
    always_ff @(posedge clk) begin
        payload <= d;
    end

    // control side, reset and bubble look the same downstream
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opcode_r   <= 7'b0;     // undefined opcode, no write no branch
            wr_reg_n_r <= 1'b1;
            kill_r     <= 1'b0;
        end else if (bubble) begin
            opcode_r   <= 7'b0;
            wr_reg_n_r <= 1'b1;
            kill_r     <= 1'b0;
        end else begin
            opcode_r   <= d.opcode;
            wr_reg_n_r <= d.wr_reg_n;
            kill_r     <= d.kill;
        end
    end

    always_comb begin
        q          = payload;
        q.opcode   = opcode_r;
        q.wr_reg_n = wr_reg_n_r;
        q.kill     = kill_r;
    end

endmodule

// File: source/alu_exec.sv
`timescale 1ns/1ns

module alu_exec
    import rv_pkg::*;
(
    input  id_ex_t  s,
    output ex_out_t ex
);

    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;
    logic            alt;         // sub / sra select
    logic [xlen-1:0] alu_out;
    logic            cond;
    logic [xlen-1:0] pc_imm;
    logic [xlen-1:0] jalr_sum;
    logic            jump;

    assign op_b     = (s.opcode == op_reg) ? s.data2 : s.imm;
    assign shamt    = op_b[4:0];
    assign alt      = s.funct7[5];
    assign pc_imm   = s.pc + s.imm;
    assign jalr_sum = s.data1 + s.imm;

    always_comb begin
        case (s.funct3)
            f3_add: begin
                // subtract exists only in register form
                if (s.opcode == op_reg && alt)
                    alu_out = s.data1 - op_b;
                else
                    alu_out = s.data1 + op_b;
            end
            f3_sll:  alu_out = s.data1 << shamt;
            f3_slt:  alu_out = {31'b0, $signed(s.data1) < $signed(op_b)};
            f3_sltu: alu_out = {31'b0, s.data1 < op_b};
            f3_xor:  alu_out = s.data1 ^ op_b;
            f3_sr: begin
                if (alt)
                    alu_out = $unsigned($signed(s.data1) >>> shamt);
                else
                    alu_out = s.data1 >> shamt;
            end
            f3_or:   alu_out = s.data1 | op_b;
            default: alu_out = s.data1 & op_b;   // f3_and
        endcase
    end

    // branch compare, funct3 010/011 never taken
    always_comb begin
        case (s.funct3)
            f3_beq:  cond = (s.data1 == s.data2);
            f3_bne:  cond = (s.data1 != s.data2);
            f3_blt:  cond = ($signed(s.data1) < $signed(s.data2));
            f3_bge:  cond = ($signed(s.data1) >= $signed(s.data2));
            f3_bltu: cond = (s.data1 < s.data2);
            f3_bgeu: cond = (s.data1 >= s.data2);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        ex.result = alu_out;
        ex.target = pc_imm;
        jump      = 1'b0;
        case (s.opcode)
            op_lui:   ex.result = s.imm;
            op_auipc: ex.result = pc_imm;
            op_jal: begin
                ex.result = s.pc4;   // link value
                jump      = 1'b1;
            end
            op_jalr: begin
                ex.result = s.pc4;
                ex.target = {jalr_sum[xlen-1:1], 1'b0};
                jump      = 1'b1;
            end
            op_branch: jump = cond;
            default: ;               // alu result stands
        endcase

        // bubble arrives as undefined opcode with wr_reg_n high
        ex.rd           = s.rd;
        ex.wr_reg_n     = s.wr_reg_n | s.kill;
        ex.branch_taken = jump & ~s.kill;
    end

endmodule

// File: source/decode_execute_top.sv
`timescale 1ns/1ns

module decode_execute_top
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    stall,
    input  logic    interlock,
    input  if_id_t  if_id,
    input  wb_t     wb,
    output ex_out_t ex
);

    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    id_ex_t      dec;     // decode stage output
    id_ex_t      id_ex;   // registered, feeds execute

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    instr_decoder u_decoder (
        .if_id    (if_id),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec)
    );

    id_ex_regs u_id_ex (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .interlock (interlock),
        .d         (dec),
        .q         (id_ex)
    );

    alu_exec u_exec (
        .s  (id_ex),
        .ex (ex)
    );

endmodule

// File: verif/decode_execute_assert.sv
`timescale 1ns/1ns

module decode_execute_assert
    import rv_pkg::*;
(
    input logic    clk,
    input logic    rst_n,
    input logic    stall,
    input logic    interlock,
    input if_id_t  if_id,
    input ex_out_t ex
);

    // first edge out of reset still sees the reset bubble
    a_reset_bubble: assert property (@(posedge clk)
        $rose(rst_n) |-> ex.wr_reg_n && !ex.branch_taken)
        else $error("execute output not idle right after reset");

    a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        (stall || interlock) |=> ex.wr_reg_n && !ex.branch_taken)
        else $error("stall or interlock did not produce a bubble");

    // killed at decode, silent one stage later
    a_kill: assert property (@(posedge clk) disable iff (!rst_n)
        (if_id.kill && !stall && !interlock) |=> ex.wr_reg_n && !ex.branch_taken)
        else $error("killed instruction wrote or branched");

    a_jalr_align: assert property (@(posedge clk) disable iff (!rst_n)
        (if_id.instr.r_fmt.opcode == op_jalr && !if_id.kill && !stall && !interlock)
        |=> ex.branch_taken && !ex.target[0])
        else $error("jalr not taken or target has bit 0 set");

endmodule

bind decode_execute_top decode_execute_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .interlock (interlock),
    .if_id     (if_id),
    .ex        (ex)
);

// File: verif/tb_decode_execute.sv
`timescale 1ns/1ns

module tb_decode_execute
    import rv_pkg::*;
();

    logic    clk;
    logic    rst_n;
    logic    stall;
    logic    interlock;
    if_id_t  if_id;
    wb_t     wb;
    ex_out_t ex;

    logic [31:0] shadow [32];   // register contents as the tb expects them
    ex_out_t     exp_q [$];
    logic [1:0]  chk_q [$];     // {result and rd meaningful, target meaningful}
    string       name_q [$];
    int          pushed;
    int          checked;
    integer      seed = 90;
    logic [6:0]  all_ops [7];
    logic [2:0]  br_f3 [6];

    decode_execute_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .interlock (interlock),
        .if_id     (if_id),
        .wb        (wb),
        .ex        (ex)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic instr_u rand_instr(input logic [6:0] op);
        instr_u ins;
        ins = $random(seed);
        ins.r_fmt.opcode = op;
        if (op == op_reg)
            ins.r_fmt.funct7 = {1'b0, ins.r_fmt.funct7[5], 5'b0};   // add/sub, srl/sra only
        return ins;
    endfunction

    // expected execute output from the rv32i rules and raw bit positions
    function automatic ex_out_t expected_ex(input if_id_t f, output logic [1:0] chk);
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        ex_out_t     e;
        w     = f.instr;
        a     = shadow[w[19:15]];
        b     = shadow[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        e     = '0;
        e.rd  = w[11:7];
        chk   = 2'b00;
        case (w[6:0])
            op_lui:   e.result = {w[31:12], 12'b0};
            op_auipc: e.result = f.pc + {w[31:12], 12'b0};
            op_jal: begin
                e.result       = f.pc + 32'd4;
                e.target       = f.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                e.branch_taken = 1'b1;
            end
            op_jalr: begin
                e.result       = f.pc + 32'd4;
                e.target       = (a + imm_i) & 32'hffff_fffe;
                e.branch_taken = 1'b1;
            end
            op_branch: begin
                e.target = f.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                case (w[14:12])
                    f3_beq:  e.branch_taken = (a == b);
                    f3_bne:  e.branch_taken = (a != b);
                    f3_blt:  e.branch_taken = ($signed(a) < $signed(b));
                    f3_bge:  e.branch_taken = ($signed(a) >= $signed(b));
                    f3_bltu: e.branch_taken = (a < b);
                    f3_bgeu: e.branch_taken = (a >= b);
                    default: e.branch_taken = 1'b0;
                endcase
            end
            op_imm, op_reg: begin
                if (w[6:0] == op_imm)
                    b = imm_i;
                case (w[14:12])
                    f3_add:  e.result = (w[6:0] == op_reg && w[30]) ? a - b : a + b;
                    f3_sll:  e.result = a << b[4:0];
                    f3_slt:  e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    f3_sltu: e.result = (a < b) ? 32'd1 : 32'd0;
                    f3_xor:  e.result = a ^ b;
                    f3_sr: begin
                        if (w[30])
                            e.result = $signed(a) >>> b[4:0];
                        else
                            e.result = a >> b[4:0];
                    end
                    f3_or:   e.result = a | b;
                    default: e.result = a & b;
                endcase
            end
            default: ;
        endcase
        e.wr_reg_n = !(w[6:0] inside {op_lui, op_auipc, op_jal, op_jalr, op_imm, op_reg});
        chk        = {!e.wr_reg_n, e.branch_taken};
        if (f.kill) begin
            e.wr_reg_n     = 1'b1;
            e.branch_taken = 1'b0;
            chk            = 2'b00;
        end
        return e;
    endfunction

    task automatic report_mismatch(input string test, input string field,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
        $display("** Error %s: %s expected %h actual %h", test, field, exp_v, act_v);
        $display("FAIL: see errors above");
        $fatal(1, "mismatch on %s", field);
    endtask

    // drive one cycle and queue what ex must show after the next edge
    task automatic issue_instr(input string name, input instr_u ins, input logic kill,
                               input logic st, input logic il, input wb_t w);
        if_id_t     f;
        ex_out_t    e;
        logic [1:0] c;
        @(posedge clk);
        #1;
        f.pc    = $random(seed) & 32'hffff_fffc;
        f.instr = ins;
        f.kill  = kill;
        if_id     = f;
        stall     = st;
        interlock = il;
        wb        = w;
        if (w.en && w.rd != 5'd0)
            shadow[w.rd] = w.data;   // decode sees the bypassed value now
        if (st || il) begin
            e          = '0;
            e.wr_reg_n = 1'b1;
            c          = 2'b00;
        end else begin
            e = expected_ex(f, c);
        end
        exp_q.push_back(e);
        chk_q.push_back(c);
        name_q.push_back(name);
        pushed++;
    endtask

    initial begin : compare
        ex_out_t    e;
        logic [1:0] c;
        string      n;
        forever begin
            @(posedge clk);
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                c = chk_q.pop_front();
                n = name_q.pop_front();
                @(negedge clk);   // ex settled
                assert (ex.wr_reg_n === e.wr_reg_n)
                    else report_mismatch(n, "wr_reg_n", 32'(e.wr_reg_n), 32'(ex.wr_reg_n));
                assert (ex.branch_taken === e.branch_taken)
                    else report_mismatch(n, "branch_taken", 32'(e.branch_taken),
                                         32'(ex.branch_taken));
                if (c[1]) begin
                    assert (ex.result === e.result)
                        else report_mismatch(n, "result", e.result, ex.result);
                    assert (ex.rd === e.rd)
                        else report_mismatch(n, "rd", 32'(e.rd), 32'(ex.rd));
                end
                if (c[0]) begin
                    assert (ex.target === e.target)
                        else report_mismatch(n, "target", e.target, ex.target);
                end
                checked++;
            end
        end
    end

    initial begin : stimulus
        wb_t    w;
        instr_u ins;
        int     k;
        int     timeout;
        rst_n     = 1'b0;
        stall     = 1'b0;
        interlock = 1'b0;
        if_id     = '0;
        wb        = '0;
        all_ops   = '{op_lui, op_auipc, op_jal, op_jalr, op_branch, op_imm, op_reg};
        br_f3     = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        for (k = 0; k < 32; k++)
            shadow[k] = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // fill x1..x31 with signed edge values in x1..x3
        for (k = 1; k < 32; k++) begin
            w.en   = 1'b1;
            w.rd   = 5'(k);
            w.data = $random(seed);
            if (k == 1) w.data = 32'h8000_0000;
            if (k == 2) w.data = 32'h7fff_ffff;
            if (k == 3) w.data = 32'hffff_ffff;
            issue_instr("load", '0, 1'b0, 1'b0, 1'b0, w);
        end

        for (k = 0; k < 60; k++)
            issue_instr("alu", rand_instr(all_ops[5 + (k % 2)]), 1'b0, 1'b0, 1'b0, '0);
        ins = rand_instr(op_reg);
        ins.r_fmt.rs1    = 5'd1;
        ins.r_fmt.rs2    = 5'd2;
        ins.r_fmt.funct7 = 7'h20;   // sub and sra
        for (k = 0; k < 8; k++) begin
            ins.r_fmt.funct3 = 3'(k);
            issue_instr("alu_edge", ins, 1'b0, 1'b0, 1'b0, '0);
        end
        ins.r_fmt.opcode = op_imm;
        ins.r_fmt.funct3 = f3_sr;   // srai
        issue_instr("srai", ins, 1'b0, 1'b0, 1'b0, '0);

        for (k = 0; k < 24; k++)
            issue_instr("jump", rand_instr(all_ops[k % 4]), 1'b0, 1'b0, 1'b0, '0);

        for (k = 0; k < 48; k++) begin
            ins = rand_instr(op_branch);
            ins.r_fmt.funct3 = br_f3[k % 6];
            if (k % 2 == 1)
                ins.r_fmt.rs2 = ins.r_fmt.rs1;   // equal operands
            issue_instr("branch", ins, 1'b0, 1'b0, 1'b0, '0);
        end

        for (k = 0; k < 40; k++)
            issue_instr("stall", rand_instr(all_ops[k % 7]), 1'b0,
                        ($random(seed) & 3) == 0, ($random(seed) & 7) == 0, '0);

        for (k = 0; k < 14; k++)
            issue_instr("kill", rand_instr(all_ops[k % 7]), 1'b1, 1'b0, 1'b0, '0);
        for (k = 0; k < 8; k++) begin
            ins = $random(seed);
            ins.r_fmt.opcode[1:0] = 2'b00;   // no rv32i opcode ends in 00
            issue_instr("unknown", ins, 1'b0, 1'b0, 1'b0, '0);
        end

        for (k = 0; k < 10; k++) begin
            w.en   = 1'b1;
            w.rd   = (k == 0) ? 5'd0 : 5'($random(seed));
            w.data = $random(seed);
            ins = rand_instr(op_reg);
            ins.r_fmt.rs1    = w.rd;
            ins.r_fmt.rs2    = (k < 2) ? 5'd0 : w.rd;
            ins.r_fmt.funct3 = f3_add;
            ins.r_fmt.funct7 = 7'h00;
            issue_instr("bypass", ins, 1'b0, 1'b0, 1'b0, w);
        end

        timeout = 0;
        while (checked != pushed && timeout < 50) begin
            @(posedge clk);
            timeout++;
        end
        if (checked == pushed) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Timed out with %0d checks still outstanding", pushed - checked);
            $display("FAIL: see errors above");
            $fatal(1, "compare process did not drain");
        end
    end

endmodule

// File: project.f
source/rv_pkg.sv
source/reg_file.sv
source/instr_decoder.sv
source/id_ex_regs.sv
source/alu_exec.sv
source/decode_execute_top.sv
verif/decode_execute_assert.sv
verif/tb_decode_execute.sv

// File: Makefile
TOP = tb_decode_execute

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
